/* include/icache_macros.svh */
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// ********************************************************************
// cache geometry
// ********************************************************************

// sets per way
`define ICACHE_DEPTH   16
// ways per set
`define ICACHE_N_WAY   2

// ********************************************************************
// address and data widths
// ********************************************************************

// word address of a fetch
`define ICACHE_ADDR_W  12
// low address bits select the set
`define ICACHE_IDX_W   4
// high address bits stored as tag
`define ICACHE_TAG_W   8
// one instruction word per line
`define ICACHE_WORD_W  32

`endif

/* logic/icache_pkg.sv */
`include "icache_macros.svh"

package icache_pkg;

    // fetched instruction word
    typedef logic [`ICACHE_WORD_W-1:0] icache_word_t;
    // stored tag
    typedef logic [`ICACHE_TAG_W-1:0]  icache_tag_t;
    // set index
    typedef logic [`ICACHE_IDX_W-1:0]  icache_idx_t;

    // controller FSM
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_LOOKUP  = 2'd1,
        ST_REFILL  = 2'd2,
        ST_RESPOND = 2'd3
    } icache_state_t;

    // config register map
    typedef enum logic [1:0] {
        REG_CTRL   = 2'd0,
        REG_HITS   = 2'd1,
        REG_MISSES = 2'd2,
        REG_STATUS = 2'd3
    } icache_reg_t;

endpackage

/* logic/icache_set_ram.sv */
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_set_ram
    import icache_pkg::*;
#(
    parameter int WIDTH = `ICACHE_WORD_W
) (
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic             req_i,
    input  logic             we_i,
    input  logic [WIDTH-1:0] data_i,
    input  icache_idx_t      addr_i,
    output logic [WIDTH-1:0] data_o
);

    // storage of one way, one entry per set
    logic [WIDTH-1:0] mem_q [`ICACHE_DEPTH];

    // single port: a write leaves the read register alone
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            data_o <= '0;
        end else if (req_i) begin
            if (we_i) begin
                mem_q[addr_i] <= data_i;
            end else begin
                data_o <= mem_q[addr_i];
            end
        end
    end

endmodule

/* logic/icache_ctrl.sv */
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_ctrl
    import icache_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rstn_i,
    // fetch and memory side
    input  logic                      req_valid_i,
    input  logic [`ICACHE_ADDR_W-1:0] req_addr_i,
    input  logic                      mem_valid_i,
    input  icache_word_t              mem_data_i,
    // from cfg
    input  logic                      en_i,
    input  logic                      flush_i,
    // ram read data
    input  icache_word_t              way0_data_i,
    input  icache_word_t              way1_data_i,
    input  icache_tag_t               way0_tag_i,
    input  icache_tag_t               way1_tag_i,
    // fetch and memory side
    output logic                      ready_o,
    output logic                      resp_valid_o,
    output icache_word_t              resp_data_o,
    output logic                      mem_req_o,
    output logic [`ICACHE_ADDR_W-1:0] mem_addr_o,
    // to cfg
    output logic                      hit_o,
    output logic                      miss_o,
    output logic                      busy_o,
    // to the rams
    output logic                      ram_req_o,
    output logic [`ICACHE_N_WAY-1:0]  ram_we_o,
    output icache_idx_t               ram_idx_o,
    output icache_word_t              ram_wdata_o,
    output icache_tag_t               ram_wtag_o
);

    // ********************************************************************
    // state and bookkeeping
    // ********************************************************************

    icache_state_t state_q;
    icache_state_t state_d;
    logic          ready_q;

    // latched fetch address and refilled word
    logic [`ICACHE_ADDR_W-1:0] addr_q;
    icache_word_t              fill_q;

    // one valid bit per way per set, one victim bit per set
    logic [`ICACHE_DEPTH-1:0][`ICACHE_N_WAY-1:0] valid_q;
    logic [`ICACHE_DEPTH-1:0]                    victim_q;

    icache_idx_t idx_q;
    icache_tag_t tag_q;
    logic        accept;
    logic        lookup;
    logic        hit0;
    logic        hit1;
    logic        hit;
    logic        refill_done;
    logic        fill_en;
    logic        victim;

    // split of the latched address
    assign idx_q = addr_q[`ICACHE_IDX_W-1:0];
    assign tag_q = addr_q[`ICACHE_ADDR_W-1:`ICACHE_IDX_W];

    // handshake on the fetch side
    assign accept = req_valid_i & ready_q;
    assign lookup = (state_q == ST_LOOKUP);

    // tag compare, both ways in parallel
    assign hit0 = valid_q[idx_q][0] & (way0_tag_i == tag_q);
    assign hit1 = valid_q[idx_q][1] & (way1_tag_i == tag_q);
    // disabled cache never hits
    assign hit  = en_i & (hit0 | hit1);

    // memory answer, filled only when enabled
    assign refill_done = (state_q == ST_REFILL) & mem_valid_i;
    assign fill_en     = refill_done & en_i;
    assign victim      = victim_q[idx_q];

    // ********************************************************************
    // FSM
    // ********************************************************************

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    state_d = ST_LOOKUP;
                end
            end
            // hit answers right here, miss goes out to memory
            ST_LOOKUP: begin
                state_d = hit ? ST_IDLE : ST_REFILL;
            end
            ST_REFILL: begin
                if (mem_valid_i) begin
                    state_d = ST_RESPOND;
                end
            end
            ST_RESPOND: begin
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q  <= ST_IDLE;
            ready_q  <= 1'b0;
            valid_q  <= '0;
            victim_q <= '0;
        end else begin
            state_q <= state_d;
            // ready again once back in idle
            ready_q <= (state_d == ST_IDLE);
            // flush wipes every set at once, victims untouched
            if (flush_i) begin
                valid_q <= '0;
            end else if (fill_en) begin
                valid_q[idx_q][victim] <= 1'b1;
                victim_q[idx_q]        <= ~victim;
            end
        end
    end

    // payload registers
    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q <= req_addr_i;
        end
        if (refill_done) begin
            fill_q <= mem_data_i;
        end
    end

    // ********************************************************************
    // outputs
    // ********************************************************************

    assign ready_o  = ready_q;
    assign busy_o   = (state_q != ST_IDLE);
    assign hit_o    = lookup & hit;
    // misses in bypass mode are not counted
    assign miss_o   = lookup & ~hit & en_i;

    assign mem_req_o  = lookup & ~hit;
    assign mem_addr_o = addr_q;

    assign resp_valid_o = hit_o | (state_q == ST_RESPOND);
    // way 0 wins if both ways ever matched
    assign resp_data_o  = (state_q == ST_RESPOND) ? fill_q :
                          (hit1 & ~hit0)          ? way1_data_i : way0_data_i;

    // read on acceptance, write on refill
    assign ram_req_o   = accept | fill_en;
    assign ram_idx_o   = accept ? req_addr_i[`ICACHE_IDX_W-1:0] : idx_q;
    assign ram_wdata_o = mem_data_i;
    assign ram_wtag_o  = tag_q;

    // write strobe only for the victim way
    always_comb begin
        ram_we_o         = '0;
        ram_we_o[victim] = fill_en;
    end

endmodule

/* logic/icache_cfg.sv */
`timescale 1ns/1ps

module icache_cfg
    import icache_pkg::*;
(
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        cfg_we_i,
    input  icache_reg_t cfg_addr_i,
    input  logic [31:0] cfg_wdata_i,
    input  logic        hit_i,
    input  logic        miss_i,
    input  logic        busy_i,
    output logic [31:0] cfg_rdata_o,
    output logic        en_o,
    output logic        flush_o
);

    logic        en_q;
    logic        flush_pend_q;
    logic [31:0] hits_q;
    logic [31:0] misses_q;

    // pending flush goes out only while the controller is idle
    assign flush_o = flush_pend_q & ~busy_i;
    assign en_o    = en_q;

    // ********************************************************************
    // register writes and event counters
    // ********************************************************************

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            en_q         <= 1'b0;
            flush_pend_q <= 1'b0;
            hits_q       <= '0;
            misses_q     <= '0;
        end else begin
            // ctrl write, bit 1 arms a flush
            if (cfg_we_i && cfg_addr_i == REG_CTRL) begin
                en_q <= cfg_wdata_i[0];
            end
            if (cfg_we_i && cfg_addr_i == REG_CTRL && cfg_wdata_i[1]) begin
                flush_pend_q <= 1'b1;
            end else if (flush_o) begin
                flush_pend_q <= 1'b0;
            end
            // any write clears a counter, otherwise count and wrap
            if (cfg_we_i && cfg_addr_i == REG_HITS) begin
                hits_q <= '0;
            end else if (hit_i) begin
                hits_q <= hits_q + 32'd1;
            end
            if (cfg_we_i && cfg_addr_i == REG_MISSES) begin
                misses_q <= '0;
            end else if (miss_i) begin
                misses_q <= misses_q + 32'd1;
            end
        end
    end

    // read mux, flush bit always reads 0
    always_comb begin
        case (cfg_addr_i)
            REG_CTRL:   cfg_rdata_o = {31'd0, en_q};
            REG_HITS:   cfg_rdata_o = hits_q;
            REG_MISSES: cfg_rdata_o = misses_q;
            REG_STATUS: cfg_rdata_o = {31'd0, busy_i};
            default:    cfg_rdata_o = '0;
        endcase
    end

endmodule

/* logic/icache_top.sv */
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_top
    import icache_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rstn_i,
    // fetch side
    input  logic                      req_valid_i,
    input  logic [`ICACHE_ADDR_W-1:0] req_addr_i,
    output logic                      ready_o,
    output logic                      resp_valid_o,
    output icache_word_t              resp_data_o,
    // memory side
    output logic                      mem_req_o,
    output logic [`ICACHE_ADDR_W-1:0] mem_addr_o,
    input  logic                      mem_valid_i,
    input  icache_word_t              mem_data_i,
    // config side
    input  logic                      cfg_we_i,
    input  icache_reg_t               cfg_addr_i,
    input  logic [31:0]               cfg_wdata_i,
    output logic [31:0]               cfg_rdata_o
);

    // cfg <-> ctrl
    logic en;
    logic flush;
    logic hit;
    logic miss;
    logic busy;

    // ctrl <-> rams
    logic                     ram_req;
    logic [`ICACHE_N_WAY-1:0] ram_we;
    icache_idx_t              ram_idx;
    icache_word_t             ram_wdata;
    icache_tag_t              ram_wtag;
    icache_word_t             way0_data;
    icache_word_t             way1_data;
    icache_tag_t              way0_tag;
    icache_tag_t              way1_tag;

    // ********************************************************************
    // controller and config block
    // ********************************************************************

    icache_ctrl i_icache_ctrl (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .req_valid_i  (req_valid_i),
        .req_addr_i   (req_addr_i),
        .mem_valid_i  (mem_valid_i),
        .mem_data_i   (mem_data_i),
        .en_i         (en),
        .flush_i      (flush),
        .way0_data_i  (way0_data),
        .way1_data_i  (way1_data),
        .way0_tag_i   (way0_tag),
        .way1_tag_i   (way1_tag),
        .ready_o      (ready_o),
        .resp_valid_o (resp_valid_o),
        .resp_data_o  (resp_data_o),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .hit_o        (hit),
        .miss_o       (miss),
        .busy_o       (busy),
        .ram_req_o    (ram_req),
        .ram_we_o     (ram_we),
        .ram_idx_o    (ram_idx),
        .ram_wdata_o  (ram_wdata),
        .ram_wtag_o   (ram_wtag)
    );

    icache_cfg i_icache_cfg (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .hit_i       (hit),
        .miss_i      (miss),
        .busy_i      (busy),
        .cfg_rdata_o (cfg_rdata_o),
        .en_o        (en),
        .flush_o     (flush)
    );

    // ********************************************************************
    // way storage, data and tag per way
    // ********************************************************************

    icache_set_ram #(.WIDTH(`ICACHE_WORD_W)) i_data_ram_0 (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .req_i  (ram_req),
        .we_i   (ram_we[0]),
        .data_i (ram_wdata),
        .addr_i (ram_idx),
        .data_o (way0_data)
    );

    icache_set_ram #(.WIDTH(`ICACHE_WORD_W)) i_data_ram_1 (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .req_i  (ram_req),
        .we_i   (ram_we[1]),
        .data_i (ram_wdata),
        .addr_i (ram_idx),
        .data_o (way1_data)
    );

    icache_set_ram #(.WIDTH(`ICACHE_TAG_W)) i_tag_ram_0 (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .req_i  (ram_req),
        .we_i   (ram_we[0]),
        .data_i (ram_wtag),
        .addr_i (ram_idx),
        .data_o (way0_tag)
    );

    icache_set_ram #(.WIDTH(`ICACHE_TAG_W)) i_tag_ram_1 (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .req_i  (ram_req),
        .we_i   (ram_we[1]),
        .data_i (ram_wtag),
        .addr_i (ram_idx),
        .data_o (way1_tag)
    );

endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rstn_o
);

    // reset low for a fixed number of rising edges
    initial begin
        clk_o  = 1'b0;
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rstn_o <= 1'b1;
    end

    always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

/* test/icache_assertions.sv */
`timescale 1ns/1ps

module icache_assertions (
    input logic clk_i,
    input logic rstn_i,
    input logic ready_i,
    input logic resp_valid_i,
    input logic mem_req_i,
    input logic mem_valid_i
);

    // refill in flight between mem_req and mem_valid
    logic outstanding_q;
    // first reset edge seen, state is known from here on
    logic reset_seen_q = 1'b0;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            outstanding_q <= 1'b0;
            reset_seen_q  <= 1'b1;
        end else if (mem_req_i) begin
            outstanding_q <= 1'b1;
        end else if (mem_valid_i) begin
            outstanding_q <= 1'b0;
        end
    end

    // ********************************************************************
    // properties
    // ********************************************************************

    mem_req_one_cycle: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_req_i |=> !mem_req_i)
        else $error("mem_req_o held longer than one cycle");

    resp_not_while_ready: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $rose(resp_valid_i) |-> !ready_i)
        else $error("resp_valid_o rose while ready_o was high");

    // no second request until the memory has answered
    single_outstanding: assert property (@(posedge clk_i) disable iff (!rstn_i)
        outstanding_q |-> !mem_req_i)
        else $error("mem_req_o raised again before mem_valid_i");

    resp_low_in_reset: assert property (@(posedge clk_i)
        (!rstn_i && reset_seen_q) |-> !resp_valid_i)
        else $error("resp_valid_o high during reset");

endmodule

/* test/icache_tb.sv */
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_tb
    import icache_pkg::*;
();

    // ********************************************************************
    // run length
    // ********************************************************************

    localparam int N_ACCESSES     = 24;
    // six register writes and thirteen register reads
    localparam int N_REG_ACCESSES = 19;
    localparam int RESET_CYCLES   = 16;
    // each register access takes at most two cycles
    localparam int CFG_CYCLES     = N_REG_ACCESSES * 2;
    localparam int TIMEOUT_CYCLES = N_ACCESSES * 30 + RESET_CYCLES + CFG_CYCLES;

    logic                      clk;
    logic                      rstn;
    logic                      req_valid;
    logic [`ICACHE_ADDR_W-1:0] req_addr;
    logic                      ready_o;
    logic                      resp_valid_o;
    icache_word_t              resp_data_o;
    logic                      mem_req_o;
    logic [`ICACHE_ADDR_W-1:0] mem_addr_o;
    logic                      mem_valid;
    icache_word_t              mem_data;
    logic                      cfg_we;
    icache_reg_t               cfg_addr;
    logic [31:0]               cfg_wdata;
    logic [31:0]               cfg_rdata_o;

    // expected counter values and enable state
    int   hits_exp;
    int   misses_exp;
    logic en_exp;
    int   cycles = 0;

    // memory model state
    logic                      req_seen;
    logic [`ICACHE_ADDR_W-1:0] req_addr_seen;
    logic [`ICACHE_ADDR_W-1:0] mem_addr_hold;
    int                        mem_wait;
    logic [31:0]               lfsr_q;
    logic [2:0]                dly_bits;

    // four sets with one tag each
    logic [`ICACHE_ADDR_W-1:0] fill_addrs [4] = '{12'h010, 12'h021, 12'h032, 12'h0a3};

    tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(RESET_CYCLES)) i_tb_clock_gen (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    icache_top i_icache_top (
        .clk_i        (clk),
        .rstn_i       (rstn),
        .req_valid_i  (req_valid),
        .req_addr_i   (req_addr),
        .ready_o      (ready_o),
        .resp_valid_o (resp_valid_o),
        .resp_data_o  (resp_data_o),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_valid_i  (mem_valid),
        .mem_data_i   (mem_data),
        .cfg_we_i     (cfg_we),
        .cfg_addr_i   (cfg_addr),
        .cfg_wdata_i  (cfg_wdata),
        .cfg_rdata_o  (cfg_rdata_o)
    );

    bind icache_ctrl icache_assertions i_icache_assertions (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .ready_i      (ready_o),
        .resp_valid_i (resp_valid_o),
        .mem_req_i    (mem_req_o),
        .mem_valid_i  (mem_valid_i)
    );

    // ********************************************************************
    // memory model
    // ********************************************************************

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // word follows from its address alone
    function automatic icache_word_t model_word(input logic [`ICACHE_ADDR_W-1:0] a);
        return {a, 8'hc3, a};
    endfunction

    // combinational mem_req_o sampled mid-cycle
    always @(negedge clk) begin
        req_seen      = mem_req_o;
        req_addr_seen = mem_addr_o;
    end

    always @(posedge clk) begin
        mem_valid <= 1'b0;
        if (mem_wait > 0) begin
            mem_wait = mem_wait - 1;
            if (mem_wait == 0) begin
                mem_valid <= 1'b1;
                mem_data  <= model_word(mem_addr_hold);
            end
        end else if (req_seen) begin
            // three lfsr bits give a delay of 1 to 8 cycles
            for (int i = 0; i < 3; i++) begin
                lfsr_q      = lfsr_next(lfsr_q);
                dly_bits[i] = lfsr_q[0];
            end
            mem_wait      = int'(dly_bits) + 1;
            mem_addr_hold = req_addr_seen;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run exceeded %0d cycles, the DUT stopped answering", TIMEOUT_CYCLES);
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout");
        end
    end

    // ********************************************************************
    // compare tasks
    // ********************************************************************

    task automatic check_word(input string name, input icache_word_t got, input icache_word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_reg(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "register mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "flag mismatch");
        end
    endtask

    // ********************************************************************
    // bus helpers
    // ********************************************************************

    task automatic write_reg(input icache_reg_t r, input logic [31:0] d);
        @(posedge clk);
        cfg_we    <= 1'b1;
        cfg_addr  <= r;
        cfg_wdata <= d;
        @(posedge clk);
        cfg_we    <= 1'b0;
    endtask

    // read data is combinational from the address
    task automatic read_reg(input icache_reg_t r, input logic [31:0] exp);
        @(posedge clk);
        cfg_addr <= r;
        @(negedge clk);
        check_reg(r.name(), cfg_rdata_o, exp);
    endtask

    // one fetch checked against hit or miss timing
    task automatic fetch(input logic [`ICACHE_ADDR_W-1:0] addr, input logic exp_hit,
                         input logic chk_busy);
        @(posedge clk);
        req_valid <= 1'b1;
        req_addr  <= addr;
        if (chk_busy) begin
            cfg_addr <= REG_STATUS;
        end
        @(negedge clk);
        while (!ready_o) @(negedge clk);
        // acceptance edge
        @(posedge clk);
        req_valid <= 1'b0;
        @(negedge clk);
        check_flag("ready_o", ready_o, 1'b0);
        if (exp_hit) begin
            check_flag("resp_valid_o", resp_valid_o, 1'b1);
            check_flag("mem_req_o", mem_req_o, 1'b0);
            check_word("resp_data_o", resp_data_o, model_word(addr));
            hits_exp++;
        end else begin
            check_flag("resp_valid_o", resp_valid_o, 1'b0);
            check_flag("mem_req_o", mem_req_o, 1'b1);
            check_reg("mem_addr_o", {20'd0, mem_addr_o}, {20'd0, addr});
            if (en_exp) begin
                misses_exp++;
            end
            @(negedge clk);
            // refill still waiting on the model here
            if (chk_busy) begin
                check_reg("REG_STATUS", cfg_rdata_o, 32'd1);
            end
            while (!resp_valid_o) @(negedge clk);
            check_word("resp_data_o", resp_data_o, model_word(addr));
        end
    endtask

    // ********************************************************************
    // directed tests
    // ********************************************************************

    task automatic reset_values();
        @(posedge rstn);
        @(posedge clk);
        @(negedge clk);
        check_flag("ready_o", ready_o, 1'b1);
        check_flag("resp_valid_o", resp_valid_o, 1'b0);
        check_flag("mem_req_o", mem_req_o, 1'b0);
        read_reg(REG_CTRL, 32'd0);
        read_reg(REG_HITS, 32'd0);
        read_reg(REG_MISSES, 32'd0);
    endtask

    task automatic enable_and_fill();
        write_reg(REG_CTRL, 32'h1);
        en_exp = 1'b1;
        foreach (fill_addrs[i]) fetch(fill_addrs[i], 1'b0, 1'b0);
        foreach (fill_addrs[i]) fetch(fill_addrs[i], 1'b1, 1'b0);
        read_reg(REG_HITS, hits_exp);
        read_reg(REG_MISSES, misses_exp);
    endtask

    // tags 1, 2, 3 all in set 5
    task automatic two_way_eviction();
        fetch(12'h105, 1'b0, 1'b0);
        fetch(12'h205, 1'b0, 1'b0);
        fetch(12'h105, 1'b1, 1'b0);
        fetch(12'h205, 1'b1, 1'b0);
        // C replaces A in way 0
        fetch(12'h305, 1'b0, 1'b0);
        fetch(12'h205, 1'b1, 1'b0);
        fetch(12'h105, 1'b0, 1'b0);
    endtask

    task automatic flush_all();
        write_reg(REG_CTRL, 32'h3);
        fetch(fill_addrs[0], 1'b0, 1'b0);
        fetch(fill_addrs[1], 1'b0, 1'b0);
        fetch(fill_addrs[2], 1'b0, 1'b0);
        fetch(12'h105, 1'b0, 1'b0);
        read_reg(REG_CTRL, 32'd1);
    endtask

    task automatic bypass_mode();
        write_reg(REG_CTRL, 32'h0);
        en_exp = 1'b0;
        fetch(12'h7e9, 1'b0, 1'b0);
        fetch(12'h7e9, 1'b0, 1'b0);
        // resident line still goes to memory
        fetch(fill_addrs[0], 1'b0, 1'b0);
        read_reg(REG_HITS, hits_exp);
        read_reg(REG_MISSES, misses_exp);
        write_reg(REG_CTRL, 32'h1);
        en_exp = 1'b1;
        fetch(12'h7e9, 1'b0, 1'b0);
        read_reg(REG_MISSES, misses_exp);
    endtask

    task automatic counter_clear_status();
        write_reg(REG_HITS, 32'hffff_ffff);
        write_reg(REG_MISSES, 32'h1);
        hits_exp   = 0;
        misses_exp = 0;
        read_reg(REG_HITS, 32'd0);
        read_reg(REG_MISSES, 32'd0);
        fetch(12'h4b7, 1'b0, 1'b1);
        read_reg(REG_STATUS, 32'd0);
        read_reg(REG_MISSES, misses_exp);
    endtask

    initial begin
        req_valid     = 1'b0;
        req_addr      = '0;
        mem_valid     = 1'b0;
        mem_data      = '0;
        cfg_we        = 1'b0;
        cfg_addr      = REG_CTRL;
        cfg_wdata     = '0;
        req_seen      = 1'b0;
        req_addr_seen = '0;
        mem_addr_hold = '0;
        mem_wait      = 0;
        lfsr_q        = 32'h157c;
        hits_exp      = 0;
        misses_exp    = 0;
        en_exp        = 1'b0;
        reset_values();
        enable_and_fill();
        two_way_eviction();
        flush_all();
        bypass_mode();
        counter_clear_status();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* icache_top.f */
+incdir+include
logic/icache_pkg.sv
logic/icache_set_ram.sv
logic/icache_ctrl.sv
logic/icache_cfg.sv
logic/icache_top.sv
test/tb_clock_gen.sv
test/icache_assertions.sv
test/icache_tb.sv

/* Makefile */
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP       := icache_tb
FILELIST  := icache_top.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
